/* source/gemm_pkg.sv */
// GEMM engine shared definitions
`default_nettype none

package gemm_pkg;

    // Array and memory sizes --------
    localparam int num_tiles         = 4;
    localparam int tile_idx_width    = $clog2(num_tiles);
    localparam int word_width        = 32;  // Command and data word
    localparam int lane_width        = 8;   // Signed element
    localparam int lanes             = word_width / lane_width;
    localparam int result_width      = 16;  // Sums wrap modulo 2^16
    localparam int mem_depth         = 64;  // Words per operand memory
    localparam int mem_addr_width    = 6;
    localparam int dim_width         = 3;   // Dimension minus one
    localparam int cmd_fifo_depth    = 16;
    localparam int result_fifo_depth = 64;

    // Command word layout --------
    localparam int op_width = 4;
    localparam int op_lsb   = 28;  // Opcode in the top nibble
    localparam int side_bit = 27;  // Load side, 0 left and 1 right
    localparam int mask_lsb = 23;  // Tile mask, num_tiles bits
    localparam int rows_lsb = 6;   // B-1
    localparam int cols_lsb = 3;   // C-1
    localparam int vec_lsb  = 0;   // V-1
    localparam int addr_lsb = 0;   // Load word address

    typedef enum logic [op_width-1:0] {
        op_nop    = 4'd0,
        op_load   = 4'd1,  // Next FIFO word is the data
        op_matmul = 4'd2
    } opcode_e;

    // Broadcast write to the tile operand memories
    typedef struct packed {
        logic                      en;
        logic [num_tiles-1:0]      mask;
        logic                      side;
        logic [mem_addr_width-1:0] addr;
        logic [word_width-1:0]     data;
    } tile_wr_t;

    // Matmul launch, start is a single-cycle pulse
    typedef struct packed {
        logic                 start;
        logic [num_tiles-1:0] mask;
        logic [dim_width-1:0] rows;
        logic [dim_width-1:0] cols;
        logic [dim_width-1:0] vec_len;
    } matmul_cmd_t;

    typedef enum logic [1:0] {mc_idle, mc_load_data, mc_wait} mc_state_e;
    typedef enum logic [1:0] {ts_idle, ts_read, ts_mac, ts_hold} tile_state_e;
    typedef enum logic [1:0] {arb_idle, arb_collect, arb_next_tile, arb_next_row} arb_state_e;

endpackage

`default_nettype wire

/* source/sync_fifo.sv */
// Show-ahead synchronous FIFO
`default_nettype none

module sync_fifo #(
    parameter int WIDTH = 32,
    parameter int DEPTH = 16   // Power of two, pointers wrap naturally
) (
    input  wire logic             i_clk,
    input  wire logic             i_reset_n,
    input  wire logic [WIDTH-1:0] i_wdata,
    input  wire logic             i_wen,
    output logic                  o_full,
    output logic      [WIDTH-1:0] o_rdata,
    input  wire logic             i_ren,
    output logic                  o_empty
);

    logic [WIDTH-1:0]         mem [DEPTH];
    logic [$clog2(DEPTH)-1:0] wr_ptr;
    logic [$clog2(DEPTH)-1:0] rd_ptr;
    logic [$clog2(DEPTH):0]   count;   // Occupancy, 0 to DEPTH
    logic                     wr_ok;
    logic                     rd_ok;

    assign wr_ok   = i_wen && !o_full;   // Write while full is dropped
    assign rd_ok   = i_ren && !o_empty;  // Read while empty is ignored
    assign o_full  = (count == DEPTH);
    assign o_empty = (count == 0);
    assign o_rdata = mem[rd_ptr];        // Head word visible without a read

    // Storage --------------------
    always_ff @(posedge i_clk) begin
        if (wr_ok) begin
            mem[wr_ptr] <= i_wdata;
        end
    end

    // Pointers and count --------------------
    always_ff @(posedge i_clk) begin
        if (!i_reset_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_ok) wr_ptr <= wr_ptr + 1'b1;
            if (rd_ok) rd_ptr <= rd_ptr + 1'b1;
            case ({wr_ok, rd_ok})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;  // Idle, or push and pop together
            endcase
        end
    end

endmodule

`default_nettype wire

/* source/master_control.sv */
// Command decoder and sequencer
`default_nettype none

module master_control (
    input  wire logic                            i_clk,
    input  wire logic                            i_reset_n,
    input  wire logic [gemm_pkg::word_width-1:0] i_cmd_data,   // FIFO head word
    input  wire logic                            i_cmd_empty,
    output logic                                 o_cmd_ren,
    output gemm_pkg::tile_wr_t                   o_tile_wr,
    output gemm_pkg::matmul_cmd_t                o_matmul,
    input  wire logic                            i_matmul_done, // From the arbiter
    output logic                                 o_busy
);

    gemm_pkg::mc_state_e state_q;
    gemm_pkg::opcode_e   opcode;
    logic [gemm_pkg::num_tiles-1:0] cmd_mask;

    // Outputs held between commands
    logic                                wr_en_q;
    logic                                start_q;
    logic [gemm_pkg::num_tiles-1:0]      mask_q;   // Shared by load and matmul
    logic                                side_q;
    logic [gemm_pkg::mem_addr_width-1:0] addr_q;
    logic [gemm_pkg::word_width-1:0]     data_q;
    logic [gemm_pkg::dim_width-1:0]      rows_q;
    logic [gemm_pkg::dim_width-1:0]      cols_q;
    logic [gemm_pkg::dim_width-1:0]      vec_q;

    // Field decode --------------------
    assign opcode   = gemm_pkg::opcode_e'(i_cmd_data[gemm_pkg::op_lsb +: gemm_pkg::op_width]);
    assign cmd_mask = i_cmd_data[gemm_pkg::mask_lsb +: gemm_pkg::num_tiles];

    // No pops while a matmul runs, so back-pressure reaches the host
    assign o_cmd_ren = !i_cmd_empty && (state_q != gemm_pkg::mc_wait);
    assign o_busy    = (state_q != gemm_pkg::mc_idle) || !i_cmd_empty;

    // FSM --------------------
    always_ff @(posedge i_clk) begin
        if (!i_reset_n) begin
            state_q <= gemm_pkg::mc_idle;
            wr_en_q <= 1'b0;
            start_q <= 1'b0;
        end else begin
            wr_en_q <= 1'b0;  // Both are single-cycle pulses
            start_q <= 1'b0;
            case (state_q)
                gemm_pkg::mc_idle: begin
                    if (!i_cmd_empty) begin
                        case (opcode)
                            gemm_pkg::op_load: state_q <= gemm_pkg::mc_load_data;
                            gemm_pkg::op_matmul: begin
                                if (|cmd_mask) begin  // Zero mask is dropped
                                    start_q <= 1'b1;
                                    state_q <= gemm_pkg::mc_wait;
                                end
                            end
                            default: state_q <= gemm_pkg::mc_idle;  // Nop and unknown
                        endcase
                    end
                end
                gemm_pkg::mc_load_data: begin
                    if (!i_cmd_empty) begin  // Data word popped here
                        wr_en_q <= 1'b1;
                        state_q <= gemm_pkg::mc_idle;
                    end
                end
                gemm_pkg::mc_wait: begin
                    if (i_matmul_done) state_q <= gemm_pkg::mc_idle;
                end
                default: state_q <= gemm_pkg::mc_idle;
            endcase
        end
    end

    // Command fields, captured on every pop in idle
    always_ff @(posedge i_clk) begin
        if (state_q == gemm_pkg::mc_idle && !i_cmd_empty) begin
            mask_q <= cmd_mask;
            side_q <= i_cmd_data[gemm_pkg::side_bit];
            addr_q <= i_cmd_data[gemm_pkg::addr_lsb +: gemm_pkg::mem_addr_width];
            rows_q <= i_cmd_data[gemm_pkg::rows_lsb +: gemm_pkg::dim_width];
            cols_q <= i_cmd_data[gemm_pkg::cols_lsb +: gemm_pkg::dim_width];
            vec_q  <= i_cmd_data[gemm_pkg::vec_lsb +: gemm_pkg::dim_width];
        end
        if (state_q == gemm_pkg::mc_load_data && !i_cmd_empty) begin
            data_q <= i_cmd_data;
        end
    end

    assign o_tile_wr = '{en: wr_en_q, mask: mask_q, side: side_q, addr: addr_q, data: data_q};
    assign o_matmul  = '{start: start_q, mask: mask_q, rows: rows_q, cols: cols_q,
                         vec_len: vec_q};

endmodule

`default_nettype wire

/* source/compute_tile.sv */
// Dot-product compute tile
`default_nettype none

module compute_tile #(
    parameter int TILE_ID = 0  // Own bit in the tile masks
) (
    input  wire logic                              i_clk,
    input  wire logic                              i_reset_n,
    input  wire gemm_pkg::tile_wr_t                i_tile_wr,
    input  wire gemm_pkg::matmul_cmd_t             i_matmul,
    output logic [gemm_pkg::result_width-1:0]      o_result_data,
    output logic                                   o_result_valid,
    input  wire logic                              i_result_ready
);

    gemm_pkg::tile_state_e state_q;

    logic [gemm_pkg::word_width-1:0]     left_mem  [gemm_pkg::mem_depth];
    logic [gemm_pkg::word_width-1:0]     right_mem [gemm_pkg::mem_depth];
    logic [gemm_pkg::word_width-1:0]     left_q;    // Operand words being multiplied
    logic [gemm_pkg::word_width-1:0]     right_q;
    logic [gemm_pkg::mem_addr_width-1:0] left_ptr;  // b*V+v
    logic [gemm_pkg::mem_addr_width-1:0] right_ptr; // c*V+v
    logic [gemm_pkg::mem_addr_width-1:0] row_base;  // b*V, left restart point per column
    logic [gemm_pkg::dim_width-1:0]      rows_q;
    logic [gemm_pkg::dim_width-1:0]      cols_q;
    logic [gemm_pkg::dim_width-1:0]      vec_q;
    logic [gemm_pkg::dim_width-1:0]      row_cnt;
    logic [gemm_pkg::dim_width-1:0]      col_cnt;
    logic [gemm_pkg::dim_width-1:0]      rd_cnt;    // Element index of the next read
    logic                                last_q;    // Last element of this sum is loaded
    logic signed [gemm_pkg::result_width-1:0] acc_q;
    logic signed [gemm_pkg::result_width-1:0] dot;
    logic signed [gemm_pkg::result_width-1:0] acc_next;
    logic signed [gemm_pkg::result_width-1:0] result_q;
    logic start_hit;
    logic do_read;
    logic accept;
    logic last_col;

    assign start_hit = i_matmul.start && i_matmul.mask[TILE_ID];
    assign do_read   = (state_q == gemm_pkg::ts_read) ||
                       (state_q == gemm_pkg::ts_mac && !last_q);  // Read overlaps MAC
    assign accept    = (state_q == gemm_pkg::ts_hold) && i_result_ready;
    assign last_col  = (col_cnt == cols_q);

    // Four signed lane products, wrapping at 16 bits
    always_comb begin
        dot = '0;
        for (int i = 0; i < gemm_pkg::lanes; i++) begin
            dot = dot + $signed(left_q[i*gemm_pkg::lane_width +: gemm_pkg::lane_width]) *
                        $signed(right_q[i*gemm_pkg::lane_width +: gemm_pkg::lane_width]);
        end
    end
    assign acc_next = acc_q + dot;

    // Operand memories --------------------
    always_ff @(posedge i_clk) begin
        if (i_tile_wr.en && i_tile_wr.mask[TILE_ID]) begin
            if (i_tile_wr.side) right_mem[i_tile_wr.addr] <= i_tile_wr.data;
            else                left_mem[i_tile_wr.addr]  <= i_tile_wr.data;
        end
    end

    // FSM --------------------
    always_ff @(posedge i_clk) begin
        if (!i_reset_n) begin
            state_q <= gemm_pkg::ts_idle;
        end else begin
            case (state_q)
                gemm_pkg::ts_idle: if (start_hit) state_q <= gemm_pkg::ts_read;
                gemm_pkg::ts_read: state_q <= gemm_pkg::ts_mac;
                gemm_pkg::ts_mac:  if (last_q) state_q <= gemm_pkg::ts_hold;
                gemm_pkg::ts_hold: begin
                    if (i_result_ready) begin
                        state_q <= (last_col && row_cnt == rows_q) ? gemm_pkg::ts_idle
                                                                   : gemm_pkg::ts_read;
                    end
                end
                default: state_q <= gemm_pkg::ts_idle;
            endcase
        end
    end

    // Loop counters and MAC datapath
    always_ff @(posedge i_clk) begin
        if (state_q == gemm_pkg::ts_idle && start_hit) begin
            rows_q    <= i_matmul.rows;
            cols_q    <= i_matmul.cols;
            vec_q     <= i_matmul.vec_len;
            row_cnt   <= '0;
            col_cnt   <= '0;
            rd_cnt    <= '0;
            left_ptr  <= '0;
            right_ptr <= '0;
            row_base  <= '0;
            acc_q     <= '0;
        end
        if (do_read) begin
            left_q    <= left_mem[left_ptr];
            right_q   <= right_mem[right_ptr];
            left_ptr  <= left_ptr + 1'b1;
            right_ptr <= right_ptr + 1'b1;
            rd_cnt    <= rd_cnt + 1'b1;
            last_q    <= (rd_cnt == vec_q);
        end
        if (state_q == gemm_pkg::ts_mac) begin
            acc_q <= acc_next;
            if (last_q) result_q <= acc_next;  // Held until accepted
        end
        if (accept) begin
            acc_q  <= '0;
            rd_cnt <= '0;
            if (last_col) begin  // Next row starts at column 0
                col_cnt   <= '0;
                row_cnt   <= row_cnt + 1'b1;
                right_ptr <= '0;
                row_base  <= left_ptr;
            end else begin       // Same row again, next column
                col_cnt   <= col_cnt + 1'b1;
                left_ptr  <= row_base;
            end
        end
    end

    assign o_result_data  = result_q;
    assign o_result_valid = (state_q == gemm_pkg::ts_hold);

endmodule

`default_nettype wire

/* source/result_arbiter.sv */
// Row-interleaved result collector
`default_nettype none

module result_arbiter (
    input  wire logic                                  i_clk,
    input  wire logic                                  i_reset_n,
    input  wire gemm_pkg::matmul_cmd_t                 i_matmul,
    input  wire logic [gemm_pkg::num_tiles-1:0][gemm_pkg::result_width-1:0] i_tile_data,
    input  wire logic [gemm_pkg::num_tiles-1:0]        i_tile_valid,
    output logic      [gemm_pkg::num_tiles-1:0]        o_tile_ready,
    input  wire logic                                  i_fifo_full,
    output logic      [gemm_pkg::result_width-1:0]     o_fifo_wdata,
    output logic                                       o_fifo_wen,
    output logic                                       o_done
);

    gemm_pkg::arb_state_e state_q;

    logic [gemm_pkg::tile_idx_width-1:0] tile_cnt;
    logic [gemm_pkg::dim_width-1:0]      row_cnt;
    logic [gemm_pkg::dim_width-1:0]      col_cnt;
    logic [gemm_pkg::num_tiles-1:0]      mask_q;
    logic [gemm_pkg::dim_width-1:0]      rows_q;
    logic [gemm_pkg::dim_width-1:0]      cols_q;
    logic                                done_q;
    logic                                take;       // Transfer tile to FIFO this cycle
    logic                                last_take;  // Final result of the matmul

    // Handshake, the only place the full flag is tested
    assign take = (state_q == gemm_pkg::arb_collect) && mask_q[tile_cnt] &&
                  i_tile_valid[tile_cnt] && !i_fifo_full;
    // Last row, last column and no enabled tile above this one
    assign last_take = (row_cnt == rows_q) && (col_cnt == cols_q) &&
                       ((mask_q >> (tile_cnt + 1)) == '0);

    always_comb begin
        o_tile_ready           = '0;
        o_tile_ready[tile_cnt] = take;
    end
    assign o_fifo_wen   = take;
    assign o_fifo_wdata = i_tile_data[tile_cnt];
    assign o_done       = done_q;

    // FSM --------------------
    always_ff @(posedge i_clk) begin
        if (!i_reset_n) begin
            state_q  <= gemm_pkg::arb_idle;
            done_q   <= 1'b0;
            tile_cnt <= '0;
            row_cnt  <= '0;
            col_cnt  <= '0;
        end else begin
            done_q <= 1'b0;
            case (state_q)
                gemm_pkg::arb_idle: begin
                    if (i_matmul.start) begin
                        tile_cnt <= '0;
                        row_cnt  <= '0;
                        col_cnt  <= '0;
                        state_q  <= gemm_pkg::arb_collect;
                    end
                end
                gemm_pkg::arb_collect: begin
                    if (!mask_q[tile_cnt]) begin
                        state_q <= gemm_pkg::arb_next_tile;  // Skip disabled tile
                    end else if (take) begin
                        if (col_cnt == cols_q) begin
                            col_cnt <= '0;
                            done_q  <= last_take;
                            state_q <= last_take ? gemm_pkg::arb_idle : gemm_pkg::arb_next_tile;
                        end else begin
                            col_cnt <= col_cnt + 1'b1;
                        end
                    end
                end
                gemm_pkg::arb_next_tile: begin
                    if (tile_cnt == gemm_pkg::num_tiles - 1) begin
                        state_q <= gemm_pkg::arb_next_row;
                    end else begin
                        tile_cnt <= tile_cnt + 1'b1;
                        state_q  <= gemm_pkg::arb_collect;
                    end
                end
                gemm_pkg::arb_next_row: begin
                    tile_cnt <= '0;
                    row_cnt  <= row_cnt + 1'b1;
                    state_q  <= gemm_pkg::arb_collect;
                end
                default: state_q <= gemm_pkg::arb_idle;
            endcase
        end
    end

    // Matmul shape, latched at start
    always_ff @(posedge i_clk) begin
        if (state_q == gemm_pkg::arb_idle && i_matmul.start) begin
            mask_q <= i_matmul.mask;
            rows_q <= i_matmul.rows;
            cols_q <= i_matmul.cols;
        end
    end

endmodule

`default_nettype wire

/* source/engine_top.sv */
// Matrix-multiply engine top level
`default_nettype none

module engine_top (
    input  wire logic                              i_clk,
    input  wire logic                              i_reset_n,
    input  wire logic [gemm_pkg::word_width-1:0]   i_cmd_wdata,   // Host command writes
    input  wire logic                              i_cmd_wen,
    output logic                                   o_cmd_full,
    output logic      [gemm_pkg::result_width-1:0] o_result_rdata, // Host result reads
    input  wire logic                              i_result_ren,
    output logic                                   o_result_empty,
    output logic                                   o_busy
);

    // Command path
    logic [gemm_pkg::word_width-1:0] cmd_rdata;
    logic                            cmd_empty;
    logic                            cmd_ren;
    gemm_pkg::tile_wr_t              tile_wr;
    gemm_pkg::matmul_cmd_t           matmul;
    logic                            matmul_done;

    // Result path
    logic [gemm_pkg::num_tiles-1:0][gemm_pkg::result_width-1:0] tile_data;
    logic [gemm_pkg::num_tiles-1:0]    tile_valid;
    logic [gemm_pkg::num_tiles-1:0]    tile_ready;
    logic [gemm_pkg::result_width-1:0] res_wdata;
    logic                              res_wen;
    logic                              res_full;

    // --------------------
    sync_fifo #(
        .WIDTH (gemm_pkg::word_width),
        .DEPTH (gemm_pkg::cmd_fifo_depth)
    ) u_cmd_fifo (
        .i_clk     (i_clk),
        .i_reset_n (i_reset_n),
        .i_wdata   (i_cmd_wdata),
        .i_wen     (i_cmd_wen),
        .o_full    (o_cmd_full),
        .o_rdata   (cmd_rdata),
        .i_ren     (cmd_ren),
        .o_empty   (cmd_empty)
    );

    master_control u_master_control (
        .i_clk         (i_clk),
        .i_reset_n     (i_reset_n),
        .i_cmd_data    (cmd_rdata),
        .i_cmd_empty   (cmd_empty),
        .o_cmd_ren     (cmd_ren),
        .o_tile_wr     (tile_wr),
        .o_matmul      (matmul),
        .i_matmul_done (matmul_done),
        .o_busy        (o_busy)
    );

    // Tile array, loads and starts broadcast to all --------------------
    for (genvar t = 0; t < gemm_pkg::num_tiles; t++) begin : gen_tile
        compute_tile #(
            .TILE_ID (t)
        ) u_tile (
            .i_clk          (i_clk),
            .i_reset_n      (i_reset_n),
            .i_tile_wr      (tile_wr),
            .i_matmul       (matmul),
            .o_result_data  (tile_data[t]),
            .o_result_valid (tile_valid[t]),
            .i_result_ready (tile_ready[t])
        );
    end

    result_arbiter u_result_arbiter (
        .i_clk        (i_clk),
        .i_reset_n    (i_reset_n),
        .i_matmul     (matmul),
        .i_tile_data  (tile_data),
        .i_tile_valid (tile_valid),
        .o_tile_ready (tile_ready),
        .i_fifo_full  (res_full),
        .o_fifo_wdata (res_wdata),
        .o_fifo_wen   (res_wen),
        .o_done       (matmul_done)
    );

    sync_fifo #(
        .WIDTH (gemm_pkg::result_width),
        .DEPTH (gemm_pkg::result_fifo_depth)
    ) u_result_fifo (
        .i_clk     (i_clk),
        .i_reset_n (i_reset_n),
        .i_wdata   (res_wdata),
        .i_wen     (res_wen),
        .o_full    (res_full),
        .o_rdata   (o_result_rdata),
        .i_ren     (i_result_ren),
        .o_empty   (o_result_empty)
    );

endmodule

`default_nettype wire

/* sim/engine_top_tb.sv */
// GEMM engine testbench
`default_nettype none

module engine_top_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int timeout_cycles = 20000;  // About four times the longest test sequence

    logic                                 i_clk;
    logic                                 i_reset_n;
    logic [gemm_pkg::word_width-1:0]      i_cmd_wdata;
    logic                                 i_cmd_wen;
    logic                                 o_cmd_full;
    logic [gemm_pkg::result_width-1:0]    o_result_rdata;
    logic                                 i_result_ren;
    logic                                 o_result_empty;
    logic                                 o_busy;

    // Reference model state
    logic [gemm_pkg::word_width-1:0]   left_m  [gemm_pkg::num_tiles][gemm_pkg::mem_depth];
    logic [gemm_pkg::word_width-1:0]   right_m [gemm_pkg::num_tiles][gemm_pkg::mem_depth];
    logic [gemm_pkg::result_width-1:0] exp_q [$];  // Results in arrival order
    logic                              stall;      // Reader holds off while set
    logic                              cmd_full_seen;
    int                                cycle_count;
    int                                kind;

    engine_top engine_top_inst (
        .i_clk          (i_clk),
        .i_reset_n      (i_reset_n),
        .i_cmd_wdata    (i_cmd_wdata),
        .i_cmd_wen      (i_cmd_wen),
        .o_cmd_full     (o_cmd_full),
        .o_result_rdata (o_result_rdata),
        .i_result_ren   (i_result_ren),
        .o_result_empty (o_result_empty),
        .o_busy         (o_busy)
    );

    always #5 i_clk = ~i_clk;

    // Helpers --------------------
    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("Finished with errors");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            abort_run($sformatf("mismatch %s: actual 0x%0h expected 0x%0h",
                                name, actual, expected));
        end
    endtask

    // Returns just after the edge that accepts the word
    task automatic push_word(input logic [31:0] word);
        @(negedge i_clk);
        while (o_cmd_full) begin  // No write until there is room
            cmd_full_seen = 1'b1;
            @(negedge i_clk);
        end
        @(posedge i_clk);
        i_cmd_wen   <= 1'b1;
        i_cmd_wdata <= word;
        @(posedge i_clk);
        i_cmd_wen <= 1'b0;
    endtask

    // Sum of signed lane products over one row and one column wrapping at 16 bits
    function automatic logic [15:0] expected_dot(input int tile, input int b, input int c,
                                                 input int vlen);
        int  sum;
        byte l_lane;
        byte r_lane;
        sum = 0;
        for (int v = 0; v < vlen; v++) begin
            for (int k = 0; k < gemm_pkg::lanes; k++) begin
                l_lane = left_m[tile][b*vlen+v][8*k +: 8];
                r_lane = right_m[tile][c*vlen+v][8*k +: 8];
                sum += int'(l_lane) * int'(r_lane);
            end
        end
        return sum[15:0];
    endfunction

    task automatic send_load(input logic side, input logic [3:0] mask,
                             input logic [5:0] addr, input logic [31:0] data);
        for (int t = 0; t < gemm_pkg::num_tiles; t++) begin
            if (mask[t] && side)  right_m[t][addr] = data;
            if (mask[t] && !side) left_m[t][addr]  = data;
        end
        push_word({4'd1, side, mask, 17'd0, addr});
        push_word(data);
    endtask

    // Expected order is row, then enabled tiles ascending, then column
    task automatic send_matmul(input logic [3:0] mask, input int rows, input int cols,
                               input int vlen);
        for (int b = 0; b < rows; b++) begin
            for (int t = 0; t < gemm_pkg::num_tiles; t++) begin
                for (int c = 0; c < cols && mask[t]; c++) begin
                    exp_q.push_back(expected_dot(t, b, c, vlen));
                end
            end
        end
        push_word({4'd2, 1'b0, mask, 14'd0, 3'(rows-1), 3'(cols-1), 3'(vlen-1)});
    endtask

    task automatic fill_tile(input logic [3:0] mask);
        for (int a = 0; a < gemm_pkg::mem_depth; a++) begin
            send_load(1'b0, mask, 6'(a), $urandom);
            send_load(1'b1, mask, 6'(a), $urandom);
        end
    endtask

    // Result reader --------------------
    always @(posedge i_clk) i_result_ren <= i_reset_n && !stall;

    always @(negedge i_clk) begin
        if (i_result_ren && !o_result_empty) begin  // Pops on the next edge
            if (exp_q.size() == 0) begin
                abort_run("result arrived while no result was expected");
            end else begin
                check_value("o_result_rdata", o_result_rdata, exp_q.pop_front());
            end
        end
    end

    always @(posedge i_clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= timeout_cycles) begin
            abort_run("timeout, the run did not finish within the cycle limit");
        end
    end

    // Tests --------------------
    initial begin
        void'($urandom(21));
        i_clk         = 1'b0;
        i_reset_n     = 1'b0;
        i_cmd_wdata   = '0;
        i_cmd_wen     = 1'b0;
        i_result_ren  = 1'b0;
        stall         = 1'b0;
        cmd_full_seen = 1'b0;
        cycle_count   = 0;
        repeat (5) @(posedge i_clk);
        i_reset_n <= 1'b1;

        @(negedge i_clk);  // Idle state after reset
        check_value("o_result_empty", o_result_empty, 1);
        check_value("o_busy", o_busy, 0);
        check_value("o_cmd_full", o_cmd_full, 0);
        @(posedge i_clk);

        fill_tile(4'b0001);  // Single tile product
        send_matmul(4'b0001, 1 + $urandom % 8, 1 + $urandom % 8, 1 + $urandom % 8);

        fill_tile(4'b0010);  // Distinct data per tile before interleaved output
        fill_tile(4'b0100);
        fill_tile(4'b1000);
        repeat (2) begin
            send_matmul(4'(1 + $urandom % 15), 1 + $urandom % 8, 1 + $urandom % 8,
                        1 + $urandom % 4);
        end

        repeat (6) begin  // Partial-mask writes seen only by their tiles
            send_load(1'($urandom), 4'(1 + $urandom % 14), 6'($urandom % 8), $urandom);
        end
        send_matmul(4'b1111, 4, 4, 2 + $urandom % 3);  // Reads cover addresses 0 to 7

        // 256 results against a 64-deep result FIFO stall the engine
        stall <= 1'b1;
        send_matmul(4'b1111, 8, 8, 1);
        fork
            begin
                repeat (8) send_load(1'($urandom), 4'($urandom), 6'($urandom), $urandom);
                repeat (4) push_word({4'd0, 28'($urandom)});
                send_matmul(4'(1 + $urandom % 15), 2, 2, 2);
            end
            begin
                for (int n = 0; n < 500 && !cmd_full_seen; n++) begin
                    @(posedge i_clk);
                end
                repeat (50) @(posedge i_clk);  // Both queues stay full a while
                stall <= 1'b0;
            end
        join
        check_value("cmd_full_seen", cmd_full_seen, 1);

        for (int i = 0; i < 40; i++) begin  // Mixed stream with dropped commands
            kind = $urandom % 5;
            case (kind)
                0: push_word({4'd0, 28'($urandom)});                     // Nop
                1: push_word({4'(3 + $urandom % 13), 28'($urandom)});    // Unknown opcode
                2: push_word({4'd2, 1'($urandom), 4'd0, 23'($urandom)}); // Zero mask
                3: send_load(1'($urandom), 4'($urandom), 6'($urandom % 16), $urandom);
                default: send_matmul(4'(1 + $urandom % 15), 1 + $urandom % 4,
                                     1 + $urandom % 4, 1 + $urandom % 4);
            endcase
        end

        @(negedge i_clk);
        while (o_busy || !o_result_empty) @(negedge i_clk);  // Engine idle and drained
        repeat (20) @(negedge i_clk);  // Room for any stray result
        check_value("o_busy", o_busy, 0);
        check_value("expected_queue_size", exp_q.size(), 0);
        check_value("o_result_empty", o_result_empty, 1);

        $display("Finished with no errors");
        $finish;
    end

endmodule

`default_nettype wire

/* engine_top.f */
source/gemm_pkg.sv
source/sync_fifo.sv
source/master_control.sv
source/compute_tile.sv
source/result_arbiter.sv
source/engine_top.sv
sim/engine_top_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the engine_top testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --timescale 1ns/1ps \
    --top-module engine_top_tb -f engine_top.f \
    --Mdir obj_dir -o engine_top_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

sim_output=$(./obj_dir/engine_top_sim 2>&1)
sim_status=$?
echo "$sim_output"
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if echo "$sim_output" | grep -qx "Finished with no errors"; then
    exit 0
fi
echo "Pass message not found in simulation output"
exit 1
